//--- design/uart_pkg.sv
////////////////////////////////////////////////////////////////////////////
// common definitions for the uart transceiver: data width, serial phase
// type and the baud divider helper. imported by the rtl and the testbench
////////////////////////////////////////////////////////////////////////////
package uart_pkg;

	localparam int DATA_W = 8; // data bits per frame

	// phase of a serial frame, shared by transmitter and receiver
	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} ser_state_t;

	// clock cycles per serial bit, rounded to nearest
	function automatic int clks_per_bit(input int clk_freq, input int baud_rate);
		int half_baud;
		half_baud = baud_rate / 2;
		return (clk_freq + half_baud) / baud_rate;
	endfunction

endpackage

//--- design/uart_tx_if.sv
////////////////////////////////////////////////////////////////////////////
// launch/status bundle between the control block and the transmitter.
// ctrl side starts a frame, phy side reports busy and done
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface uart_tx_if;
	import uart_pkg::*;

	logic              start;   // one-cycle launch pulse
	logic [DATA_W-1:0] tx_byte; // byte to send, sampled with start
	logic              busy;    // frame in progress
	logic              done;    // pulse after last stop bit

	modport ctrl (
		output start,
		output tx_byte,
		input  busy,
		input  done
	);

	modport phy (
		input  start,
		input  tx_byte,
		output busy,
		output done
	);

endinterface

//--- design/uart_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// valid/ready front end of the uart. holds one byte for the transmitter
// and keeps the receive output register with the sticky overrun flag
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_ctrl (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic [uart_pkg::DATA_W-1:0] s_data,
	input  logic                        s_valid,
	output logic                        s_ready,
	output logic [uart_pkg::DATA_W-1:0] m_data,
	output logic                        m_valid,
	input  logic                        m_ready,
	output logic                        rx_overrun,
	output logic                        rx_frame_err,
	uart_tx_if.ctrl                     tx,
	input  logic [uart_pkg::DATA_W-1:0] rx_byte,
	input  logic                        rx_strobe,
	input  logic                        frame_err
);
	import uart_pkg::*;

	logic [DATA_W-1:0] hold_byte;
	logic              hold_full;
	logic              hold_full_nxt;
	logic              accept;
	logic              tx_idle;
	logic              m_take;

	assign accept  = s_valid && s_ready;
	assign tx_idle = !tx.busy && !tx.start; // launch pulse not yet seen as busy
	assign m_take  = m_valid && m_ready;

	// the holding byte only fills while a frame is running, so it is
	// always released by the done pulse of that frame
	always_comb begin
		hold_full_nxt = hold_full;
		if (accept && !tx_idle)
			hold_full_nxt = 1'b1;
		else if (hold_full && tx.done)
			hold_full_nxt = 1'b0;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			hold_full <= 1'b0;
			s_ready   <= 1'b0;
			tx.start  <= 1'b0;
		end else begin
			hold_full <= hold_full_nxt;
			s_ready   <= !hold_full_nxt;
			tx.start  <= (accept && tx_idle) || (hold_full && tx.done);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			hold_byte <= s_data;
		if (accept && tx_idle)
			tx.tx_byte <= s_data; // straight through when idle
		else if (hold_full && tx.done)
			tx.tx_byte <= hold_byte;
	end

	// receive side
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			m_valid      <= 1'b0;
			rx_overrun   <= 1'b0;
			rx_frame_err <= 1'b0;
		end else begin
			rx_frame_err <= frame_err;
			if (rx_strobe && !m_valid)
				m_valid <= 1'b1;
			else if (m_take)
				m_valid <= 1'b0;
			if (rx_strobe && m_valid)
				rx_overrun <= 1'b1; // new byte dropped
			else if (m_take)
				rx_overrun <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_strobe && !m_valid)
			m_data <= rx_byte;
	end

endmodule

//--- design/uart_tx.sv
////////////////////////////////////////////////////////////////////////////
// bit-serial transmitter. a start pulse on the interface sends one frame:
// start bit, DATA_W data bits lsb first, then STOP_BITS stop bits
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int STOP_BITS = 1
) (
	input  logic   sys_clk,
	input  logic   sys_rst_n,
	uart_tx_if.phy tx,
	output logic   txd
);
	import uart_pkg::*;

	localparam int CPB   = clks_per_bit(CLK_FREQ, BAUD_RATE);
	localparam int CNT_W = $clog2(CPB + 1);
	localparam int BIT_W = $clog2(DATA_W);

	ser_state_t        state;
	logic [CNT_W-1:0]  cnt_clk; // cycles within a bit
	logic [BIT_W-1:0]  cnt_bit; // data or stop bit index
	logic [DATA_W-1:0] shift_reg;
	logic              bit_end;
	logic              last_data;
	logic              last_stop;

	assign bit_end   = (cnt_clk == CNT_W'(CPB - 1));
	assign last_data = (cnt_bit == BIT_W'(DATA_W - 1));
	assign last_stop = (cnt_bit == BIT_W'(STOP_BITS - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:  if (tx.start) state <= st_start;
				st_start: if (bit_end) state <= st_data;
				st_data:  if (bit_end && last_data) state <= st_stop;
				st_stop:  if (bit_end && last_stop) state <= st_idle;
				default:  state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			cnt_clk <= '0;
		else if (state == st_idle || bit_end)
			cnt_clk <= '0;
		else
			cnt_clk <= cnt_clk + CNT_W'(1);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			cnt_bit <= '0;
		else if (state == st_idle || state == st_start)
			cnt_bit <= '0;
		else if (bit_end)
			cnt_bit <= (state == st_data && last_data) ? '0 : cnt_bit + BIT_W'(1);
	end

	// line driver plus busy/done status
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			txd     <= 1'b1;
			tx.busy <= 1'b0;
			tx.done <= 1'b0;
		end else begin
			tx.done <= 1'b0;
			if (state == st_idle && tx.start) begin
				txd     <= 1'b0; // start bit
				tx.busy <= 1'b1;
			end else if (state == st_start && bit_end) begin
				txd <= shift_reg[0];
			end else if (state == st_data && bit_end) begin
				txd <= last_data ? 1'b1 : shift_reg[0];
			end else if (state == st_stop && bit_end && last_stop) begin
				tx.busy <= 1'b0;
				tx.done <= 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == st_idle && tx.start)
			shift_reg <= tx.tx_byte;
		else if ((state == st_start || state == st_data) && bit_end)
			shift_reg <= shift_reg >> 1; // next bit to position 0
	end

endmodule

//--- design/uart_rx.sv
////////////////////////////////////////////////////////////////////////////
// serial receiver. synchronises rxd, finds the start edge, samples every
// bit at mid-bit and checks the first stop bit before handing the byte on
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int STOP_BITS = 1
) (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic                        rxd,
	output logic [uart_pkg::DATA_W-1:0] rx_byte,
	output logic                        rx_strobe,
	output logic                        frame_err
);
	import uart_pkg::*;

	localparam int CPB   = clks_per_bit(CLK_FREQ, BAUD_RATE);
	localparam int HALF  = CPB / 2;
	localparam int CNT_W = $clog2(CPB + 1);
	localparam int BIT_W = $clog2(DATA_W);

	ser_state_t        state;
	logic              rxd_meta;
	logic              rxd_sync;
	logic              rxd_prev; // for edge detect
	logic [CNT_W-1:0]  cnt_clk;
	logic [BIT_W-1:0]  cnt_bit;
	logic [DATA_W-1:0] shift_reg;
	logic              fall;
	logic              half_end;
	logic              bit_end;
	logic              period_end;
	logic              stop_check;

	assign fall       = rxd_prev && !rxd_sync;
	assign half_end   = (cnt_clk == CNT_W'(HALF - 1));
	assign bit_end    = (cnt_clk == CNT_W'(CPB - 1));
	assign period_end = (state == st_start) ? half_end : bit_end;
	assign stop_check = (state == st_stop) && bit_end && (cnt_bit == '0); // mid first stop

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= st_idle;
			cnt_bit <= '0;
		end else begin
			case (state)
				st_idle: begin
					cnt_bit <= '0;
					if (fall)
						state <= st_start;
				end
				st_start: begin
					if (half_end)
						state <= rxd_sync ? st_idle : st_data; // glitch goes back to idle
				end
				st_data: begin
					if (bit_end) begin
						cnt_bit <= cnt_bit + BIT_W'(1);
						if (cnt_bit == BIT_W'(DATA_W - 1)) begin
							cnt_bit <= '0;
							state   <= st_stop;
						end
					end
				end
				st_stop: begin
					// re-arm at mid of the last stop bit
					if (bit_end) begin
						cnt_bit <= cnt_bit + BIT_W'(1);
						if (cnt_bit == BIT_W'(STOP_BITS - 1))
							state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			cnt_clk <= '0;
		else if (state == st_idle || period_end)
			cnt_clk <= '0;
		else
			cnt_clk <= cnt_clk + CNT_W'(1);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_strobe <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			rx_strobe <= stop_check && rxd_sync;
			frame_err <= stop_check && !rxd_sync; // byte discarded
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == st_data && bit_end)
			shift_reg <= {rxd_sync, shift_reg[DATA_W-1:1]}; // lsb arrives first
		if (stop_check && rxd_sync)
			rx_byte <= shift_reg;
	end

endmodule

//--- design/uart_top.sv
////////////////////////////////////////////////////////////////////////////
// uart transceiver top. valid/ready byte ports on one side, txd/rxd on
// the other. baud and stop bit settings are passed to both serial blocks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_top #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200,
	parameter int STOP_BITS = 1
) (
	input  logic                        sys_clk,
	input  logic                        sys_rst_n,
	input  logic [uart_pkg::DATA_W-1:0] s_data,
	input  logic                        s_valid,
	output logic                        s_ready,
	output logic [uart_pkg::DATA_W-1:0] m_data,
	output logic                        m_valid,
	input  logic                        m_ready,
	output logic                        rx_overrun,
	output logic                        rx_frame_err,
	output logic                        txd,
	input  logic                        rxd
);
	import uart_pkg::*;

	logic [DATA_W-1:0] rx_byte;
	logic              rx_strobe;
	logic              frame_err;

	uart_tx_if tx_bus ();

	uart_ctrl u_ctrl (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.s_data       (s_data),
		.s_valid      (s_valid),
		.s_ready      (s_ready),
		.m_data       (m_data),
		.m_valid      (m_valid),
		.m_ready      (m_ready),
		.rx_overrun   (rx_overrun),
		.rx_frame_err (rx_frame_err),
		.tx           (tx_bus.ctrl),
		.rx_byte      (rx_byte),
		.rx_strobe    (rx_strobe),
		.frame_err    (frame_err)
	);

	uart_tx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.STOP_BITS (STOP_BITS)
	) u_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx        (tx_bus.phy),
		.txd       (txd)
	);

	uart_rx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.STOP_BITS (STOP_BITS)
	) u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (rxd),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe),
		.frame_err (frame_err)
	);

endmodule

//--- test/uart_sva.sv
////////////////////////////////////////////////////////////////////////////
// assertions on the serial line and the byte handshakes of the uart.
// bound into uart_top, failures are counted for the end of the run
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_sva #(
	parameter int BIT_CYCLES = 16
) (
	input logic                        sys_clk,
	input logic                        sys_rst_n,
	input logic                        txd,
	input uart_pkg::ser_state_t        tx_state,
	input logic                        s_ready,
	input logic [uart_pkg::DATA_W-1:0] m_data,
	input logic                        m_valid,
	input logic                        m_ready
);
	import uart_pkg::*;

	int fail_count = 0;

	// line idles high between frames
	idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_state == st_idle |-> txd)
	else begin
		$error("txd low while the transmitter is idle");
		fail_count++;
	end

	start_len: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(tx_state == st_start) |->
			(!txd && tx_state == st_start) [*BIT_CYCLES] ##1 tx_state == st_data)
	else begin
		$error("start bit length is wrong");
		fail_count++;
	end

	m_data_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		m_valid && !m_ready |=> $stable(m_data))
	else begin
		$error("m_data changed while waiting for m_ready");
		fail_count++;
	end

	// outputs settle one edge into reset
	reset_low: assert property (@(posedge sys_clk)
		!sys_rst_n |=> !s_ready && !m_valid)
	else begin
		$error("s_ready or m_valid high during reset");
		fail_count++;
	end

endmodule

bind uart_top uart_sva u_sva (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.txd       (txd),
	.tx_state  (u_tx.state),
	.s_ready   (s_ready),
	.m_data    (m_data),
	.m_valid   (m_valid),
	.m_ready   (m_ready)
);

//--- test/uart_checker.sv
////////////////////////////////////////////////////////////////////////////
// receive side scoreboard. the testbench queues the bytes and flags it
// expects, every m_valid/m_ready transfer is compared against the queue
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module uart_checker (
	input logic                        sys_clk,
	input logic                        sys_rst_n,
	input logic [uart_pkg::DATA_W-1:0] m_data,
	input logic                        m_valid,
	input logic                        m_ready,
	input logic                        rx_overrun,
	input logic                        rx_frame_err
);
	import uart_pkg::*;

	logic [DATA_W:0] exp_q[$]; // {overrun, byte}
	logic            m_valid_q;
	int              err_count  = 0;
	int              bytes_seen = 0;
	int              ferr_exp   = 0;
	int              ferr_seen  = 0;

	task automatic expect_byte(input logic [DATA_W-1:0] d, input logic ovr);
		exp_q.push_back({ovr, d});
	endtask

	task automatic expect_frame_err();
		ferr_exp++;
	endtask

	task automatic note_failure(input string what);
		$display("%s", what);
		err_count++;
	endtask

	task automatic value_error(input string name, input int got, input int want);
		$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
		err_count++;
	endtask

	task automatic check_wait(input string name, input int got, input int lo, input int hi);
		if (got < lo || got > hi) begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h to 0x%0h", name, got, lo, hi);
			err_count++;
		end
	endtask

	always @(posedge sys_clk or negedge sys_rst_n) begin : watch
		logic [DATA_W:0] want;
		if (!sys_rst_n) begin
			m_valid_q <= 1'b0;
		end else begin
			m_valid_q <= m_valid;
			if (m_valid && !m_valid_q && exp_q.size() == 0)
				note_failure("m_valid rose while no byte was expected");
			if (m_valid && m_ready && exp_q.size() != 0) begin
				want = exp_q.pop_front();
				bytes_seen++;
				if (m_data !== want[DATA_W-1:0])
					value_error("m_data", m_data, want[DATA_W-1:0]);
				if (rx_overrun !== want[DATA_W])
					value_error("rx_overrun", rx_overrun, want[DATA_W]);
			end
			if (rx_frame_err) begin
				if (ferr_seen >= ferr_exp)
					note_failure("rx_frame_err pulsed without a bad frame");
				ferr_seen++;
			end
		end
	end

	task automatic report(input int sva_fails);
		if (exp_q.size() != 0)
			note_failure($sformatf("%0d expected bytes never arrived", exp_q.size()));
		if (ferr_seen < ferr_exp)
			value_error("rx_frame_err pulse count", ferr_seen, ferr_exp);
		err_count += sva_fails;
		$display("checks done: %0d bytes, %0d frame errors, %0d assertion failures, %0d errors",
			bytes_seen, ferr_seen, sva_fails, err_count);
	endtask

endmodule

//--- test/tb_uart.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the uart top. reads test/uart_cases.txt, drives the byte
// ports and loops txd back to rxd or bit-bangs frames onto rxd itself
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_uart;
	import uart_pkg::*;

	localparam int CLK_FREQ  = 1_600_000;
	localparam int BAUD_RATE = 100_000;
	localparam int STOP_BITS = 2;
	localparam int CPB       = clks_per_bit(CLK_FREQ, BAUD_RATE);
	localparam int FRAME     = (1 + DATA_W + STOP_BITS) * CPB;

	logic              sys_clk;
	logic              sys_rst_n;
	logic [DATA_W-1:0] s_data;
	logic              s_valid;
	logic              s_ready;
	logic [DATA_W-1:0] m_data;
	logic              m_valid;
	logic              m_ready;
	logic              rx_overrun;
	logic              rx_frame_err;
	logic              txd;
	logic              rxd;
	logic              inject; // tb drives rxd
	logic              rxd_bb;

	assign rxd = inject ? rxd_bb : txd;

	uart_top #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.STOP_BITS (STOP_BITS)
	) uut (.*);

	uart_checker chk (.*);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	task automatic send_byte(input logic [DATA_W-1:0] d, output int waits);
		s_valid <= 1'b1;
		s_data  <= d;
		waits = 0;
		do begin
			@(posedge sys_clk);
			if (!s_ready)
				waits++;
		end while (!s_ready && waits < 3 * FRAME);
		if (!s_ready)
			chk.note_failure("timeout waiting for s_ready with a byte pending");
		s_valid <= 1'b0;
	endtask

	task automatic take_bytes(input int n, input int hold);
		int t;
		for (int i = 0; i < n; i++) begin
			t = 0;
			do begin
				@(posedge sys_clk);
				t++;
			end while (!m_valid && t < 4 * FRAME);
			if (!m_valid)
				chk.note_failure("timeout waiting for m_valid on an expected byte");
			repeat (hold) @(posedge sys_clk);
			m_ready <= 1'b1;
			@(posedge sys_clk);
			m_ready <= 1'b0;
		end
	endtask

	task automatic inject_frame(input logic [DATA_W-1:0] d);
		logic [DATA_W+3:0] bits;
		bits = {2'b11, 1'b0, d, 1'b0}; // idle tail, low stop bit, data, start
		inject <= 1'b1;
		for (int i = 0; i < DATA_W + 4; i++) begin
			rxd_bb <= bits[i];
			repeat (CPB) @(posedge sys_clk);
		end
		inject <= 1'b0;
	endtask

	task automatic run_case(input logic [7:0] kind, input logic [DATA_W-1:0] d,
			input int hold, input int ovr, input int ferr);
		int waits;
		repeat (2 * CPB + $urandom % 8) @(posedge sys_clk); // transmitter idle again
		if (ferr != 0)
			chk.expect_frame_err();
		if (kind == "L") begin
			chk.expect_byte(d, ovr[0]);
			fork
				send_byte(d, waits);
				take_bytes(1, hold);
			join
		end else if (kind == "B") begin
			chk.expect_byte(d, ovr[0]);
			if (ovr == 0)
				chk.expect_byte(d ^ 8'hff, 1'b0); // dropped on overrun
			chk.expect_byte(d + 8'd1, 1'b0);
			fork
				begin
					send_byte(d, waits);
					send_byte(d ^ 8'hff, waits);
					chk.check_wait("s_ready low cycles, second byte", waits, 0, 0);
					send_byte(d + 8'd1, waits);
					chk.check_wait("s_ready low cycles, third byte", waits, FRAME - 4, FRAME + 8);
				end
				take_bytes(ovr != 0 ? 2 : 3, hold);
			join
		end else if (kind == "F") begin
			inject_frame(d);
		end else begin
			chk.note_failure("unknown case kind in the case file");
		end
	endtask

	initial begin : stimulus
		int                fd;
		int                n;
		string             line;
		logic [7:0]        kind;
		logic [DATA_W-1:0] d;
		int                hold;
		int                ovr;
		int                ferr;
		sys_rst_n = 1'b0;
		s_valid   = 1'b0;
		s_data    = '0;
		m_ready   = 1'b0;
		inject    = 1'b0;
		rxd_bb    = 1'b1;
		void'($urandom(32'h6b4b3c35));
		repeat (2) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		fd = $fopen("test/uart_cases.txt", "r");
		if (fd == 0)
			chk.note_failure("could not open test/uart_cases.txt");
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%c %h %d %d %d", kind, d, hold, ovr, ferr);
				if (n == 5)
					run_case(kind, d, hold, ovr, ferr);
				else
					chk.note_failure("malformed line in the case file");
			end
		end
		if (fd != 0)
			$fclose(fd);
		repeat (4 * CPB) @(posedge sys_clk);
		chk.report(uut.u_sva.fail_count);
		if (chk.err_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- list.f
design/uart_pkg.sv
design/uart_tx_if.sv
design/uart_ctrl.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
test/uart_sva.sv
test/uart_checker.sv
test/tb_uart.sv

//--- test/uart_cases.txt
# kind byte(hex) m_ready_holdoff(cycles) exp_overrun exp_frame_err
# L loopback, B burst (byte, byte^ff, byte+1), F injected frame with a low stop bit
L 55 0 0 0
L a3 3 0 0
L 00 12 0 0
L ff 1 0 0
B 3c 0 0 0
B 81 20 0 0
L 7e 5 0 0
B c4 250 1 0
L 19 2 0 0
F 5a 0 0 1
L 5a 0 0 0
F e7 0 0 1
L 26 7 0 0
B 0f 250 1 0
L f0 40 0 0
B 6d 9 0 0
